/* bench/i2cPollChecker.sv */
/*
 * Model is updated from observed AXI writes and decoded I2C addresses
 * Busy bit is compared only once the bus has been quiet while disabled
 */
`include "i2cPoll_defs.svh"

module i2cPollChecker
(
	input logic        iSysClk,
	input logic        rst,
	input logic [31:0] awaddr,
	input logic        awvalid,
	input logic        awready,
	input logic [31:0] wdata,
	input logic        wready,
	input logic [1:0]  bresp,
	input logic        bvalid,
	input logic        bready,
	input logic [31:0] araddr,
	input logic        arvalid,
	input logic        arready,
	input logic [31:0] rdata,
	input logic [1:0]  rresp,
	input logic        rvalid,
	input logic        rready,
	input logic        scl,
	input logic        sda,
	input logic [2:0]  presentMask
);
	timeunit 1ns;
	timeprecision 1ps;

	// --------------------
	// Model state
	logic        modelEn;
	logic [15:0] modelDiv;
	logic [23:0] modelSadrs;
	logic [15:0] expData [3];
	logic [2:0]  modelNack;
	// NACK seen on the bus, flag not yet visible
	logic [2:0]  nackPend;
	logic [1:0]  expSlot;
	logic [1:0]  expBresp;
	logic [31:0] expRdata;
	logic [31:0] rdMask;
	logic [1:0]  expRresp;
	logic        prevScl;
	logic        prevSda;
	logic        inAddr;
	logic [3:0]  bitCnt;
	logic [7:0]  shift;
	logic [31:0] idleCnt;
	logic        settled;

	int errCount  = 0;
	int errAtTest = 0;
	int passCount = 0;
	int failCount = 0;
	int addrCount = 0;

	assign settled = !modelEn &&
		(idleCnt > 32'd8 * ((modelDiv == 16'd0) ? 32'd1 : 32'(modelDiv)) + 32'd20);

	task automatic report(input string msg);
		errCount++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic endTest(input string name);
		if (errCount == errAtTest)
		begin
			passCount++;
			$display("PASS test %s", name);
		end
		else
		begin
			failCount++;
			$display("test %s failed with %0d errors", name, errCount - errAtTest);
		end
		errAtTest = errCount;
	endtask

	task automatic summary();
		$display("tests passed %0d, failed %0d, check errors %0d",
			passCount, failCount, errCount);
	endtask

	function automatic logic [6:0] adrOf(input logic [1:0] s);
		logic [23:0] w;
		w = modelSadrs >> (8 * s);
		return w[6:0];
	endfunction

	function automatic logic rdOk(input logic [31:0] a);
		if (a[15:8] != `I2C_BLOCK_BASE)
			return 1'b0;
		case (a[7:0])
			`I2C_REG_EN, `I2C_REG_DIV, `I2C_REG_SADRS, `I2C_REG_DATA0,
			`I2C_REG_DATA1, `I2C_REG_DATA2, `I2C_REG_STAT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Expected word from the model, 0 for error reads
	function automatic logic [31:0] rdWordOf(input logic [31:0] a);
		if (!rdOk(a))
			return 32'd0;
		case (a[7:0])
			`I2C_REG_EN:    return {31'd0, modelEn};
			`I2C_REG_DIV:   return {16'd0, modelDiv};
			`I2C_REG_SADRS: return {8'd0, modelSadrs};
			`I2C_REG_DATA0: return {16'd0, expData[0]};
			`I2C_REG_DATA1: return {16'd0, expData[1]};
			`I2C_REG_DATA2: return {16'd0, expData[2]};
			default:        return {28'd0, modelNack, 1'b0};
		endcase
	endfunction

	always @(posedge iSysClk)
	begin
		logic       wOk;
		logic [7:0] adrByte;
		if (rst)
		begin
			modelEn    <= 1'b0;
			modelDiv   <= `I2C_DIV_RST;
			modelSadrs <= '0;
			expData    <= '{default: '0};
			modelNack  <= '0;
			nackPend   <= '0;
			expSlot    <= 2'd0;
			prevScl    <= 1'b1;
			prevSda    <= 1'b1;
			inAddr     <= 1'b0;
			bitCnt     <= '0;
			idleCnt    <= '0;
		end
		else
		begin
			// --------------------
			// AXI writes
			// Address and data channels are taken together
			if (awready != wready)
				report($sformatf("awready %0d, wready %0d, expected equal", awready, wready));
			if (awvalid && awready)
			begin
				wOk = (awaddr[15:8] == `I2C_BLOCK_BASE) && ((awaddr[7:0] == `I2C_REG_EN) ||
					(awaddr[7:0] == `I2C_REG_DIV) || (awaddr[7:0] == `I2C_REG_SADRS));
				expBresp <= wOk ? 2'b00 : 2'b10;
				if (wOk && awaddr[7:0] == `I2C_REG_EN)
				begin
					// Fresh enable restarts at slot 0
					if (wdata[0] && !modelEn)
						expSlot <= 2'd0;
					modelEn   <= wdata[0];
					modelNack <= '0;
				end
				else if (wOk && awaddr[7:0] == `I2C_REG_DIV)
					modelDiv <= wdata[15:0];
				else if (wOk)
					modelSadrs <= wdata[23:0];
			end
			if (bvalid && bready && bresp != expBresp)
				report($sformatf("write response %0d, expected %0d", bresp, expBresp));

			// --------------------
			// AXI reads
			if (arvalid && arready)
			begin
				expRdata <= rdWordOf(araddr);
				expRresp <= rdOk(araddr) ? 2'b00 : 2'b10;
				rdMask   <= 32'hFFFF_FFFF;
				if (rdOk(araddr) && araddr[7:0] == `I2C_REG_STAT)
					rdMask <= ~{28'd0, nackPend, !settled};
			end
			if (rvalid && rready)
			begin
				if ((rdata & rdMask) != (expRdata & rdMask) || rresp != expRresp)
					report($sformatf("read data %h resp %0d, expected %h resp %0d",
						rdata, rresp, expRdata, expRresp));
			end

			// --------------------
			// I2C decode
			prevScl <= scl;
			prevSda <= sda;
			if (!scl || !sda)
				idleCnt <= '0;
			else
				idleCnt <= idleCnt + 32'd1;
			if (settled && (!scl || !sda))
				report("bus became active while polling was disabled");
			if (prevScl && scl && prevSda && !sda)
			begin
				inAddr <= 1'b1;
				bitCnt <= '0;
			end
			else if (prevScl && scl && !prevSda && sda)
			begin
				modelNack <= modelNack | nackPend;
				nackPend  <= '0;
			end
			else if (!prevScl && scl && inAddr)
			begin
				bitCnt  <= bitCnt + 4'd1;
				shift   <= {shift[6:0], sda};
				adrByte = {adrOf(expSlot), 1'b1};
				if (bitCnt == 4'd7)
				begin
					addrCount++;
					if ({shift[6:0], sda} != adrByte)
						report($sformatf("address byte %h, expected %h for slot %0d",
							{shift[6:0], sda}, adrByte, expSlot));
				end
				else if (bitCnt == 4'd8)
				begin
					// Slave answers with the address byte and its inverse
					if (presentMask[expSlot])
						expData[expSlot] <= {adrByte, ~adrByte};
					else
						nackPend[expSlot] <= 1'b1;
					expSlot <= (expSlot == 2'd2) ? 2'd0 : expSlot + 2'd1;
					inAddr  <= 1'b0;
				end
			end
		end
	end

endmodule

/* bench/i2cPollTb.sv */
/*
 * Slave model answers the present slots only, with the address byte and its inverse
 * Stimulus changes on the falling clock edge
 */
`include "i2cPoll_defs.svh"

module i2cPollTb;
	timeunit 1ns;
	timeprecision 1ps;

	// Three polling tests of three rounds at the largest divider, plus AXI margin
	localparam int DivMax = 9;
	localparam int Limit  = 3 * 3 * 3 * 30 * 4 * DivMax + 20000;

	logic        iSysClk;
	logic        rst;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        sclOe;
	logic        sdaOe;
	logic        scl;
	logic        sda;
	logic [2:0]  presentMask;
	logic [6:0]  tbAdr [3];
	int          seed;
	logic [31:0] rnd;
	int          cycles;

	// Slave model state
	logic       slvDrv;
	logic       slvMatch;
	logic       slvByte;
	logic       pScl;
	logic       pSda;
	logic [1:0] slvState;
	logic [3:0] slvCnt;
	logic [7:0] slvAdr;
	logic [7:0] slvTx;

	// Open-drain lines with pullups
	assign scl = !sclOe;
	assign sda = !(sdaOe || slvDrv);

	tbClkGen uClk (.iSysClk(iSysClk), .rst(rst));

	i2cPollTop UUT
	(
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.sclOe(sclOe), .sdaOe(sdaOe), .sclIn(scl), .sdaIn(sda),
		.iSysClk(iSysClk), .rst(rst)
	);

	i2cPollChecker chk
	(
		.iSysClk(iSysClk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
		.wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.scl(scl), .sda(sda), .presentMask(presentMask)
	);

	function automatic logic [31:0] regAddr(input logic [7:0] off);
		return {16'd0, `I2C_BLOCK_BASE, off};
	endfunction

	function automatic logic addrMatch(input logic [7:0] a);
		for (int i = 0; i < 3; i++)
			if (presentMask[i] && a[7:1] == tbAdr[i])
				return 1'b1;
		return 1'b0;
	endfunction

	// --------------------
	// I2C slave model
	always @(posedge iSysClk)
	begin
		if (rst)
		begin
			slvDrv   <= 1'b0;
			slvState <= 2'd0;
			pScl     <= 1'b1;
			pSda     <= 1'b1;
		end
		else
		begin
			pScl <= scl;
			pSda <= sda;
			if (pScl && scl && pSda && !sda)
			begin
				slvState <= 2'd1;
				slvCnt   <= '0;
				slvDrv   <= 1'b0;
			end
			else if (pScl && scl && !pSda && sda)
			begin
				slvState <= 2'd0;
				slvDrv   <= 1'b0;
			end
			else if (!pScl && scl && slvState != 2'd0)
			begin
				if (slvState == 2'd1 && slvCnt < 4'd8)
					slvAdr <= {slvAdr[6:0], sda};
				slvCnt <= slvCnt + 4'd1;
			end
			else if (pScl && !scl)
			begin
				if (slvState == 2'd1 && slvCnt == 4'd8)
				begin
					// Address ack only when present
					slvMatch <= addrMatch(slvAdr);
					slvDrv   <= addrMatch(slvAdr);
				end
				else if (slvState == 2'd1 && slvCnt == 4'd9)
				begin
					slvState <= slvMatch ? 2'd2 : 2'd0;
					slvByte  <= 1'b0;
					slvTx    <= slvAdr;
					slvCnt   <= '0;
					slvDrv   <= slvMatch && !slvAdr[7];
				end
				else if (slvState == 2'd2 && slvCnt == 4'd9)
				begin
					// Second byte is the inverse, then let go
					slvByte  <= 1'b1;
					slvTx    <= ~slvAdr;
					slvCnt   <= '0;
					slvDrv   <= !slvByte && slvAdr[7];
					slvState <= slvByte ? 2'd0 : 2'd2;
				end
				else if (slvState == 2'd2 && slvCnt < 4'd8)
					slvDrv <= !slvTx[3'd7 - slvCnt[2:0]];
				else
					slvDrv <= 1'b0;
			end
		end
	end

	// --------------------
	// AXI tasks
	task automatic axiWrite(input logic [31:0] a, input logic [31:0] d);
		@(negedge iSysClk);
		awaddr  = a;
		wdata   = d;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		#1;
		while (!awready)
		begin
			@(negedge iSysClk);
			#1;
		end
		@(negedge iSysClk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge iSysClk);
		// Response waits one cycle before it is taken
		@(negedge iSysClk);
		bready = 1'b1;
		@(negedge iSysClk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [31:0] a);
		@(negedge iSysClk);
		araddr  = a;
		arvalid = 1'b1;
		#1;
		while (!arready)
		begin
			@(negedge iSysClk);
			#1;
		end
		@(negedge iSysClk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge iSysClk);
		// Read data must hold while rready is low
		@(negedge iSysClk);
		rready = 1'b1;
		@(negedge iSysClk);
		rready = 1'b0;
	endtask

	// Distinct addresses, slot number in the low bits
	task automatic pickAddresses();
		rnd = $random(seed);
		for (int i = 0; i < 3; i++)
			tbAdr[i] = {rnd[i*5 +: 5], 2'(i)};
		axiWrite(regAddr(`I2C_REG_SADRS),
			{8'd0, rnd[31], tbAdr[2], rnd[30], tbAdr[1], rnd[29], tbAdr[0]});
	endtask

	task automatic waitAddrs(input int n);
		int target;
		target = chk.addrCount + n;
		wait (chk.addrCount >= target);
	endtask

	task automatic readData();
		axiRead(regAddr(`I2C_REG_DATA0));
		axiRead(regAddr(`I2C_REG_DATA1));
		axiRead(regAddr(`I2C_REG_DATA2));
	endtask

	// --------------------
	// Timeout
	always @(posedge iSysClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= Limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", Limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		seed        = 24;
		cycles      = 0;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		presentMask = 3'b111;
		tbAdr       = '{default: '0};
		@(negedge rst);

		// Config registers read back masked
		for (int k = 0; k < 4; k++)
		begin
			rnd = $random(seed);
			axiWrite(regAddr(`I2C_REG_EN), rnd & ~32'd1);
			axiRead(regAddr(`I2C_REG_EN));
			rnd = $random(seed);
			axiWrite(regAddr(`I2C_REG_DIV), rnd);
			axiRead(regAddr(`I2C_REG_DIV));
			rnd = $random(seed);
			axiWrite(regAddr(`I2C_REG_SADRS), rnd);
			axiRead(regAddr(`I2C_REG_SADRS));
		end
		chk.endTest("register readback");

		// Outside the block, unmapped, read-only
		axiWrite({16'd0, `I2C_BLOCK_BASE + 8'd1, `I2C_REG_DIV}, 32'd7);
		axiWrite(regAddr(8'h10), 32'hFFFF_FFFF);
		axiWrite(regAddr(`I2C_REG_DATA0), 32'h1234);
		axiRead({16'd0, `I2C_BLOCK_BASE + 8'd1, `I2C_REG_EN});
		axiRead(regAddr(8'h90));
		axiRead(regAddr(`I2C_REG_EN));
		axiRead(regAddr(`I2C_REG_DIV));
		axiRead(regAddr(`I2C_REG_SADRS));
		axiRead(regAddr(`I2C_REG_DATA0));
		chk.endTest("decode errors");

		// Polling with every slave present
		rnd = $random(seed);
		axiWrite(regAddr(`I2C_REG_DIV), {29'd0, rnd[2:0]} + 32'd2);
		pickAddresses();
		axiWrite(regAddr(`I2C_REG_EN), 32'd1);
		axiRead(regAddr(`I2C_REG_EN));
		waitAddrs(7);
		chk.endTest("slot order");

		axiWrite(regAddr(`I2C_REG_EN), 32'd0);
		wait (chk.settled);
		axiWrite(regAddr(`I2C_REG_EN), 32'd0);
		readData();
		chk.endTest("round data");

		// One slot absent
		pickAddresses();
		rnd = $random(seed);
		presentMask = 3'b111 & ~(3'd1 << ((rnd[1:0] == 2'd3) ? 2'd1 : rnd[1:0]));
		axiWrite(regAddr(`I2C_REG_EN), 32'd1);
		waitAddrs(4);
		axiRead(regAddr(`I2C_REG_STAT));
		axiWrite(regAddr(`I2C_REG_EN), 32'd0);
		wait (chk.settled);
		readData();
		axiWrite(regAddr(`I2C_REG_EN), 32'd0);
		axiRead(regAddr(`I2C_REG_STAT));
		chk.endTest("sticky nack");

		// Disable mid-round, then watch a quiet bus
		presentMask = 3'b111;
		axiWrite(regAddr(`I2C_REG_EN), 32'd1);
		waitAddrs(2);
		axiWrite(regAddr(`I2C_REG_EN), 32'd0);
		wait (chk.settled);
		repeat (400) @(posedge iSysClk);
		axiRead(regAddr(`I2C_REG_STAT));
		chk.endTest("disable to idle");

		chk.summary();
		if (chk.errCount == 0 && chk.failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* bench/i2cPoll_assertions.sv */
/*
 * Bound into i2cPollTop, checks only the master side of SDA
 */
module i2cPollAssertions
(
	input logic               iSysClk,
	input logic               rst,
	input logic               bvalid,
	input logic               bready,
	input logic               rvalid,
	input logic               rready,
	input logic [31:0]        rdata,
	input logic               sclOe,
	input logic               sdaOe,
	input i2cPollPkg::cmdKind kindR
);
	timeunit 1ns;
	timeprecision 1ps;

	// Responses held until taken
	bHold: assert property (@(posedge iSysClk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rHold: assert property (@(posedge iSysClk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	rStable: assert property (@(posedge iSysClk) disable iff (rst)
		rvalid && !rready |=> rdata == $past(rdata))
		else $error("rdata changed while rvalid waited");

	// SDA moves under a high SCL only for start and stop
	sdaRule: assert property (@(posedge iSysClk) disable iff (rst)
		(!sclOe && !$past(sclOe) && (sdaOe != $past(sdaOe))) |->
		(kindR == i2cPollPkg::CMD_START || kindR == i2cPollPkg::CMD_STOP))
		else $error("SDA changed while SCL high outside start or stop");

endmodule

bind i2cPollTop i2cPollAssertions uAsrt
(
	.iSysClk(iSysClk), .rst(rst),
	.bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.sclOe(sclOe), .sdaOe(sdaOe),
	.kindR(uEngine.kindR)
);

/* bench/tbClkGen.sv */
/*
 * 20 ns clock, reset high for the first 5 cycles
 */
module tbClkGen
(
	output logic iSysClk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		iSysClk = 1'b0;
		forever
			#10 iSysClk = !iSysClk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (5) @(posedge iSysClk);
		// Release away from the active edge
		@(negedge iSysClk);
		rst = 1'b0;
	end

endmodule

/* i2cPoll.f */
+incdir+rtl
rtl/i2cPollPkg.sv
rtl/i2cAxiCsr.sv
rtl/i2cPollSeq.sv
rtl/i2cBitEngine.sv
rtl/i2cPollTop.sv
bench/tbClkGen.sv
bench/i2cPoll_assertions.sv
bench/i2cPollChecker.sv
bench/i2cPollTb.sv

/* rtl/i2cAxiCsr.sv */
/*
 * Write strobes are ignored, every write stores a full word
 * Data and status registers are read-only, a write to them returns SLVERR
 */
`include "i2cPoll_defs.svh"

module i2cAxiCsr
(
	input  logic                   iSysClk,
	input  logic                   rst,
	input  logic [`I2C_ADDR_W-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [`I2C_DATA_W-1:0] wdata,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [`I2C_ADDR_W-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [`I2C_DATA_W-1:0] rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	output logic                   pollEn,
	output logic [15:0]            div,
	output i2cPollPkg::slaveAdrs   sAdrs,
	input  logic                   resultValid,
	input  logic [1:0]             resultSlot,
	input  logic [15:0]            resultData,
	input  logic [`I2C_SLOTS-1:0]  nackSlot,
	input  logic                   busy
);

	logic                   wrAccept;
	logic                   wrHit;
	logic                   wrErr;
	logic                   enWrite;
	logic                   rdAccept;
	logic                   rdErr;
	logic [`I2C_DATA_W-1:0] rdWord;
	logic [15:0]            dataReg [`I2C_SLOTS];
	logic [`I2C_SLOTS-1:0]  nackFlags;

	// --------------------
	// Write channel
	// Both address and data must be present, and no response pending
	assign wrAccept = awvalid && wvalid && !bvalid;
	assign awready  = wrAccept;
	assign wready   = wrAccept;
	assign wrHit    = (awaddr[15:8] == `I2C_BLOCK_BASE);
	// Only the three config registers are writable
	assign wrErr    = !wrHit || !((awaddr[7:0] == `I2C_REG_EN) ||
		(awaddr[7:0] == `I2C_REG_DIV) || (awaddr[7:0] == `I2C_REG_SADRS));
	assign enWrite  = wrAccept && wrHit && (awaddr[7:0] == `I2C_REG_EN);

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			pollEn <= 1'b0;
			div    <= `I2C_DIV_RST;
			sAdrs  <= '0;
		end
		else if (wrAccept && !wrErr)
		begin
			// New enable acts in the acceptance edge
			case (awaddr[7:0])
				`I2C_REG_EN:    pollEn    <= wdata[0];
				`I2C_REG_DIV:   div       <= wdata[15:0];
				`I2C_REG_SADRS: sAdrs.raw <= wdata[`I2C_SLOTS*8-1:0];
				default:        pollEn    <= pollEn;
			endcase
		end
	end

	// Write response one cycle after acceptance
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			bvalid <= 1'b0;
		else if (wrAccept)
		begin
			bvalid <= 1'b1;
			bresp  <= wrErr ? 2'b10 : 2'b00;
		end
		else if (bready)
			bvalid <= 1'b0;
	end

	// --------------------
	// Polled results
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			dataReg   <= '{default: '0};
			nackFlags <= '0;
		end
		else
		begin
			if (resultValid)
				dataReg[resultSlot] <= resultData;
			// Sticky, cleared by any enable write, new NACK wins
			nackFlags <= (enWrite ? '0 : nackFlags) | nackSlot;
		end
	end

	// --------------------
	// Read channel
	assign rdAccept = arvalid && !rvalid;
	assign arready  = rdAccept;

	always_comb
	begin
		rdWord = '0;
		rdErr  = 1'b0;
		if (araddr[15:8] != `I2C_BLOCK_BASE)
			rdErr = 1'b1;
		else
		begin
			case (araddr[7:0])
				`I2C_REG_EN:    rdWord[0]                = pollEn;
				`I2C_REG_DIV:   rdWord[15:0]             = div;
				`I2C_REG_SADRS: rdWord[`I2C_SLOTS*8-1:0] = sAdrs.raw;
				`I2C_REG_DATA0: rdWord[15:0]             = dataReg[0];
				`I2C_REG_DATA1: rdWord[15:0]             = dataReg[1];
				`I2C_REG_DATA2: rdWord[15:0]             = dataReg[2];
				// Busy in bit 0, NACK flags above it
				`I2C_REG_STAT:  rdWord[`I2C_SLOTS:0]     = {nackFlags, busy};
				default:        rdErr                    = 1'b1;
			endcase
		end
	end

	// Read data held steady until rready
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			rvalid <= 1'b0;
		else if (rdAccept)
		begin
			rvalid <= 1'b1;
			rdata  <= rdWord;
			rresp  <= rdErr ? 2'b10 : 2'b00;
		end
		else if (rready)
			rvalid <= 1'b0;
	end

endmodule

/* rtl/i2cBitEngine.sv */
/*
 * Bit time is 4 x max(div, 1) cycles; SCL is never stretched by the slave
 * sdaIn is taken as already synchronous to iSysClk
 */
module i2cBitEngine
(
	input  logic               iSysClk,
	input  logic               rst,
	input  logic [15:0]        div,
	input  logic               cmdValid,
	output logic               cmdReady,
	input  i2cPollPkg::cmdKind cmdKind,
	input  logic [7:0]         txByte,
	input  logic               ackOut,
	output logic               done,
	output logic [7:0]         rxByte,
	output logic               ackIn,
	output logic               sclOe,
	output logic               sdaOe,
	input  logic               sdaIn
);

	logic               busyR;
	logic               accept;
	logic               tick;
	logic               lastBit;
	logic [15:0]        divEff;
	logic [15:0]        qCnt;
	logic [1:0]         quarter;
	logic [3:0]         bitCnt;
	i2cPollPkg::cmdKind kindR;
	logic [7:0]         shReg;
	logic               ackOutR;

	// Pull-low enables {scl, sda} for one quarter of a command
	function automatic logic [1:0] lineOe(input i2cPollPkg::cmdKind kind,
		input logic [1:0] q, input logic [3:0] bitIdx, input logic txBit, input logic ackBit);
		logic sclL;
		logic sdaL;
		case (kind)
			// SDA falls while SCL high, then SCL low
			i2cPollPkg::CMD_START:
			begin
				sclL = (q == 2'd3);
				sdaL = (q >= 2'd2);
			end
			// SDA rises while SCL high
			i2cPollPkg::CMD_STOP:
			begin
				sclL = (q == 2'd0);
				sdaL = (q <= 2'd1);
			end
			i2cPollPkg::CMD_WRITE:
			begin
				sclL = (q == 2'd0) || (q == 2'd3);
				sdaL = (bitIdx == 4'd8) ? 1'b0 : !txBit;
			end
			default:
			begin
				sclL = (q == 2'd0) || (q == 2'd3);
				sdaL = (bitIdx == 4'd8) ? ackBit : 1'b0;
			end
		endcase
		return {sclL, sdaL};
	endfunction

	assign cmdReady = !busyR;
	assign accept   = cmdValid && !busyR;
	assign divEff   = (div == 16'd0) ? 16'd1 : div;
	assign tick     = busyR && (qCnt == 16'd0);
	// Start and stop are a single bit, bytes carry 8 data bits and an ack
	assign lastBit  = (kindR == i2cPollPkg::CMD_START) || (kindR == i2cPollPkg::CMD_STOP) ||
		(bitCnt == 4'd8);
	assign rxByte   = shReg;

	// --------------------
	// Quarter and bit sequencing
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			busyR   <= 1'b0;
			qCnt    <= '0;
			quarter <= '0;
			bitCnt  <= '0;
			done    <= 1'b0;
			sclOe   <= 1'b0;
			sdaOe   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (accept)
			begin
				busyR          <= 1'b1;
				qCnt           <= divEff - 16'd1;
				quarter        <= 2'd0;
				bitCnt         <= 4'd0;
				{sclOe, sdaOe} <= lineOe(cmdKind, 2'd0, 4'd0, txByte[7], ackOut);
			end
			else if (busyR && !tick)
				qCnt <= qCnt - 16'd1;
			else if (tick)
			begin
				qCnt <= divEff - 16'd1;
				if (quarter != 2'd3)
				begin
					quarter        <= quarter + 2'd1;
					{sclOe, sdaOe} <= lineOe(kindR, quarter + 2'd1, bitCnt, shReg[7], ackOutR);
				end
				else if (lastBit)
				begin
					// Lines hold their last level until the next command
					busyR <= 1'b0;
					done  <= 1'b1;
				end
				else
				begin
					quarter        <= 2'd0;
					bitCnt         <= bitCnt + 4'd1;
					{sclOe, sdaOe} <= lineOe(kindR, 2'd0, bitCnt + 4'd1, shReg[6], ackOutR);
				end
			end
		end
	end

	// --------------------
	// Shift and sample
	always_ff @(posedge iSysClk)
	begin
		if (accept)
		begin
			kindR   <= cmdKind;
			shReg   <= txByte;
			ackOutR <= ackOut;
		end
		else if (tick)
		begin
			// End of quarter 1 is the SCL high midpoint
			if (quarter == 2'd1 && bitCnt == 4'd8)
				ackIn <= !sdaIn;
			else if (quarter == 2'd1 && kindR == i2cPollPkg::CMD_READ)
				shReg <= {shReg[6:0], sdaIn};
			// Next write bit MSB first
			if (quarter == 2'd3 && kindR == i2cPollPkg::CMD_WRITE)
				shReg <= {shReg[6:0], 1'b0};
		end
	end

endmodule

/* rtl/i2cPollPkg.sv */
/*
 * Shared types of the I2C polling controller
 */
`include "i2cPoll_defs.svh"

package i2cPollPkg;

	// Bit engine commands, one in flight at a time
	typedef enum logic [1:0]
	{
		CMD_START = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2,
		CMD_STOP  = 2'd3
	} cmdKind;

	// Slave address word
	// Raw field for the register block, per-slot bytes for the sequencer
	// Slot 0 sits in the low byte, bit 7 of each byte is unused
	typedef union packed
	{
		logic [`I2C_SLOTS*8-1:0]    raw;
		logic [`I2C_SLOTS-1:0][7:0] slot;
	} slaveAdrs;

endpackage

/* rtl/i2cPollSeq.sv */
/*
 * Slots run 0, 1, 2 and wrap; a disable is honoured only after the slot's stop
 * Re-enabling always restarts at slot 0
 */
`include "i2cPoll_defs.svh"

module i2cPollSeq
(
	input  logic                  iSysClk,
	input  logic                  rst,
	input  logic                  pollEn,
	input  i2cPollPkg::slaveAdrs  sAdrs,
	output logic                  cmdValid,
	input  logic                  cmdReady,
	output i2cPollPkg::cmdKind    cmdKind,
	output logic [7:0]            txByte,
	output logic                  ackOut,
	input  logic                  done,
	input  logic [7:0]            rxByte,
	input  logic                  ackIn,
	output logic                  resultValid,
	output logic [1:0]            resultSlot,
	output logic [15:0]           resultData,
	output logic [`I2C_SLOTS-1:0] nackSlot,
	output logic                  busy
);

	// FSM states, one per bus command
	localparam logic [2:0] SIdle  = 3'd0;
	localparam logic [2:0] SStart = 3'd1;
	localparam logic [2:0] SAddr  = 3'd2;
	localparam logic [2:0] SRdHi  = 3'd3;
	localparam logic [2:0] SRdLo  = 3'd4;
	localparam logic [2:0] SStop  = 3'd5;

	logic [2:0] state;
	logic [1:0] slot;
	logic       waitDone;
	logic [7:0] hiByte;

	// --------------------
	// Command side
	assign busy     = (state != SIdle);
	// Hold valid until the engine takes it, then wait for done
	assign cmdValid = busy && !waitDone;
	// Read address of the current slot
	assign txByte   = {sAdrs.slot[slot][6:0], 1'b1};
	// Ack the high byte, NACK the low byte to end the read
	assign ackOut   = (state == SRdHi);

	always_comb
	begin
		case (state)
			SStart:       cmdKind = i2cPollPkg::CMD_START;
			SAddr:        cmdKind = i2cPollPkg::CMD_WRITE;
			SRdHi, SRdLo: cmdKind = i2cPollPkg::CMD_READ;
			default:      cmdKind = i2cPollPkg::CMD_STOP;
		endcase
	end

	// --------------------
	// Slot walk
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state       <= SIdle;
			slot        <= 2'd0;
			waitDone    <= 1'b0;
			resultValid <= 1'b0;
			nackSlot    <= '0;
		end
		else
		begin
			resultValid <= 1'b0;
			nackSlot    <= '0;
			if (cmdValid && cmdReady)
				waitDone <= 1'b1;
			if (state == SIdle)
			begin
				if (pollEn)
					state <= SStart;
			end
			else if (done)
			begin
				waitDone <= 1'b0;
				case (state)
					SStart: state <= SAddr;
					SAddr:
					begin
						// Absent slave skips straight to stop
						if (ackIn)
							state <= SRdHi;
						else
						begin
							nackSlot <= `I2C_SLOTS'(1) << slot;
							state    <= SStop;
						end
					end
					SRdHi:
					begin
						hiByte <= rxByte;
						state  <= SRdLo;
					end
					SRdLo:
					begin
						resultValid <= 1'b1;
						resultSlot  <= slot;
						resultData  <= {hiByte, rxByte};
						state       <= SStop;
					end
					default:
					begin
						if (pollEn)
						begin
							slot  <= (slot == 2'(`I2C_SLOTS - 1)) ? 2'd0 : slot + 2'd1;
							state <= SStart;
						end
						else
						begin
							slot  <= 2'd0;
							state <= SIdle;
						end
					end
				endcase
			end
		end
	end

endmodule

/* rtl/i2cPollTop.sv */
/*
 * sclIn is unused since clock stretching is not supported
 */
`include "i2cPoll_defs.svh"

module i2cPollTop
(
	input  logic [`I2C_ADDR_W-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [`I2C_DATA_W-1:0] wdata,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [`I2C_ADDR_W-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [`I2C_DATA_W-1:0] rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	output logic                   sclOe,
	output logic                   sdaOe,
	input  logic                   sclIn,
	input  logic                   sdaIn,
	input  logic                   iSysClk,
	input  logic                   rst
);

	// Register block to sequencer and engine
	logic                  pollEn;
	logic [15:0]           div;
	i2cPollPkg::slaveAdrs  sAdrs;
	logic                  resultValid;
	logic [1:0]            resultSlot;
	logic [15:0]           resultData;
	logic [`I2C_SLOTS-1:0] nackSlot;
	logic                  busy;
	// Sequencer to engine command handshake
	logic                  cmdValid;
	logic                  cmdReady;
	i2cPollPkg::cmdKind    cmdKind;
	logic [7:0]            txByte;
	logic                  ackOut;
	logic                  done;
	logic [7:0]            rxByte;
	logic                  ackIn;

	i2cAxiCsr uCsr
	(
		.iSysClk(iSysClk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.pollEn(pollEn), .div(div), .sAdrs(sAdrs),
		.resultValid(resultValid), .resultSlot(resultSlot), .resultData(resultData),
		.nackSlot(nackSlot), .busy(busy)
	);

	i2cPollSeq uSeq
	(
		.iSysClk(iSysClk), .rst(rst), .pollEn(pollEn), .sAdrs(sAdrs),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdKind(cmdKind),
		.txByte(txByte), .ackOut(ackOut), .done(done), .rxByte(rxByte), .ackIn(ackIn),
		.resultValid(resultValid), .resultSlot(resultSlot), .resultData(resultData),
		.nackSlot(nackSlot), .busy(busy)
	);

	i2cBitEngine uEngine
	(
		.iSysClk(iSysClk), .rst(rst), .div(div),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdKind(cmdKind),
		.txByte(txByte), .ackOut(ackOut), .done(done), .rxByte(rxByte), .ackIn(ackIn),
		.sclOe(sclOe), .sdaOe(sdaOe), .sdaIn(sdaIn)
	);

endmodule

/* rtl/i2cPoll_defs.svh */
/*
 * Block decode uses address bits 15 to 8 only; upper address bits are ignored
 */
`ifndef I2C_POLL_DEFS_SVH
`define I2C_POLL_DEFS_SVH

// Block number matched against address bits 15:8
`define I2C_BLOCK_BASE 8'h01

// Register byte offsets
`define I2C_REG_EN     8'h00
`define I2C_REG_DIV    8'h04
`define I2C_REG_SADRS  8'h08
`define I2C_REG_DATA0  8'h80
`define I2C_REG_DATA1  8'h84
`define I2C_REG_DATA2  8'h88
`define I2C_REG_STAT   8'h8C

// AXI4-Lite bus widths
`define I2C_ADDR_W 32
`define I2C_DATA_W 32

// Polled slaves per round
`define I2C_SLOTS 3
// Quarter-bit divider after reset
`define I2C_DIV_RST 16'd125

`endif

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert -Wno-fatal --top-module i2cPollTb -f i2cPoll.f \
	&& ./obj_dir/Vi2cPollTb | grep -F "STATUS: PASS" \
	|| exit 1
